//--- pk_consts.svh
`ifndef PK_CONSTS_SVH
`define PK_CONSTS_SVH

// Width of one incoming symbol in bits
`define PK_SYM_WIDTH 2
// Number of symbols that fill one packed word
`define PK_SYMS_PER_WORD 4
// Width of one packed output word in bits
`define PK_WORD_WIDTH 8
// Slot counter width, enough to index every symbol position in a word
`define PK_SLOT_WIDTH 2
// Per-frame word counter width, the count wraps modulo 256
`define PK_COUNT_WIDTH 8

`endif

//--- pk_stream_pkg.sv
`include "pk_consts.svh"

package pk_stream_pkg;

	// One symbol as delivered by the source
	typedef logic [`PK_SYM_WIDTH-1:0] sym_t;

	// One packed word with the earliest symbol of the word in the low bits
	// Positions that a closing word does not fill are zero
	typedef logic [`PK_WORD_WIDTH-1:0] word_t;

endpackage

//--- pk_ctrl_pkg.sv
`include "pk_consts.svh"

package pk_ctrl_pkg;

	// FRAME_IDLE means no symbol of the next frame has been taken yet
	// FRAME_OPEN means symbols were taken but the last one has not arrived
	// FRAME_CLOSING means the last symbol was taken and its word is still in flight
	typedef enum logic [1:0] {
		FRAME_IDLE,
		FRAME_OPEN,
		FRAME_CLOSING
	} frame_state_e;

	// Number of words one frame produced
	typedef logic [`PK_COUNT_WIDTH-1:0] word_count_t;

endpackage

//--- packer.sv
`timescale 1ns/1ps
`include "pk_consts.svh"

module packer
	(input  logic                 clk_i
	,input  logic                 reset_i

	,input  pk_stream_pkg::sym_t  sym_i
	,input  logic                 valid_i
	,input  logic                 flush_i
	,output logic                 ready_o

	,output pk_stream_pkg::word_t word_o
	,output logic                 word_last_o
	,output logic                 word_valid_o
	,input  logic                 elastic_ready_i
	);

	import pk_stream_pkg::*;

	// Index of the slot that the next accepted symbol goes into
	logic [`PK_SLOT_WIDTH-1:0] slot_r;
	// Symbols of the current word collected so far
	word_t                     acc_r;

	// Incoming symbol moved to the bit position of its slot
	word_t                     sym_shifted_w;
	int unsigned               bit_offset_w;

	logic                      final_slot_w;
	logic                      in_fire_w;
	logic                      emit_w;

	// The next symbol would complete the word
	assign final_slot_w = (slot_r == `PK_SLOT_WIDTH'(`PK_SYMS_PER_WORD - 1));

	// A symbol that completes or closes a word can only be taken when the
	// output stage has room for it, every other symbol is always taken
	assign ready_o = (final_slot_w || flush_i) ? elastic_ready_i : 1'b1;

	assign in_fire_w = valid_i && ready_o;

	// A word leaves in the very cycle its closing symbol is accepted
	assign emit_w = in_fire_w && (final_slot_w || flush_i);

	// Symbol k of a word sits at bits 2k and 2k+1
	assign bit_offset_w  = int'(slot_r) * `PK_SYM_WIDTH;
	assign sym_shifted_w = word_t'(sym_i) << bit_offset_w;

	// The presented word is the accumulator with the current symbol merged in
	// Unfilled upper slots are still zero, so a closing word comes out zero padded
	assign word_o       = acc_r | sym_shifted_w;
	assign word_valid_o = emit_w;
	// Only a word closed by the frame's last symbol carries the last tag
	assign word_last_o  = flush_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			slot_r <= '0;
			acc_r  <= '0;
		end else if (emit_w) begin
			// Word handed to the output stage, start a fresh one
			slot_r <= '0;
			acc_r  <= '0;
		end else if (in_fire_w) begin
			// Keep the merged symbol and move on to the next slot
			slot_r <= slot_r + 1'b1;
			acc_r  <= word_o;
		end
	end

endmodule

//--- elastic.sv
`timescale 1ns/1ps

module elastic
	(input  logic                 clk_i
	,input  logic                 reset_i

	,input  pk_stream_pkg::word_t data_i
	,input  logic                 last_i
	,input  logic                 valid_i
	,output logic                 ready_o

	,output pk_stream_pkg::word_t data_o
	,output logic                 last_o
	,output logic                 valid_o
	,input  logic                 ready_i
	);

	import pk_stream_pkg::*;

	// Held word and its last tag
	word_t data_r;
	logic  last_r;
	// The stage holds a word that has not been taken yet
	logic  valid_r;

	// Room is available when empty or when the held word leaves this cycle
	assign ready_o = !valid_r || ready_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_r <= 1'b0;
		end else if (ready_o) begin
			valid_r <= valid_i;
		end
	end

	// Payload only changes on a load, so it stays still under back-pressure
	always_ff @(posedge clk_i) begin
		if (ready_o && valid_i) begin
			data_r <= data_i;
			last_r <= last_i;
		end
	end

	assign data_o  = data_r;
	assign last_o  = last_r;
	assign valid_o = valid_r;

endmodule

//--- frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl
	(input  logic                     clk_i
	,input  logic                     reset_i

	,input  logic                     sym_valid_i
	,input  logic                     sym_last_i
	,output logic                     sym_ready_o

	,output logic                     pk_valid_o
	,output logic                     pk_flush_o
	,input  logic                     pk_ready_i

	,input  logic                     out_valid_i
	,input  logic                     out_ready_i
	,input  logic                     out_last_i

	,output pk_ctrl_pkg::word_count_t frame_words_o
	,output logic                     frame_done_o
	);

	import pk_ctrl_pkg::*;

	frame_state_e state_r;
	frame_state_e state_n;

	// Words of the current frame already delivered downstream
	word_count_t  count_r;
	// Count published for the last finished frame
	word_count_t  words_r;
	logic         done_r;

	logic         closing_w;
	logic         in_fire_w;
	logic         out_fire_w;
	logic         close_fire_w;

	assign closing_w = (state_r == FRAME_CLOSING);

	// Symbols are held off while a finished frame drains
	// This keeps the words of two frames out of one count
	assign pk_valid_o  = sym_valid_i && !closing_w;
	assign pk_flush_o  = sym_valid_i && sym_last_i;
	assign sym_ready_o = pk_ready_i && !closing_w;

	assign in_fire_w    = sym_valid_i && sym_ready_o;
	assign out_fire_w   = out_valid_i && out_ready_i;
	// The tagged word marks the end of the frame on the output side
	assign close_fire_w = out_fire_w && out_last_i;

	always_comb begin
		state_n = state_r;
		unique case (state_r)
			FRAME_IDLE: begin
				if (in_fire_w) begin
					// A one-symbol frame goes straight to closing
					state_n = sym_last_i ? FRAME_CLOSING : FRAME_OPEN;
				end
			end
			FRAME_OPEN: begin
				if (in_fire_w && sym_last_i) begin
					state_n = FRAME_CLOSING;
				end
			end
			FRAME_CLOSING: begin
				if (close_fire_w) begin
					state_n = FRAME_IDLE;
				end
			end
			default: state_n = FRAME_IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_r <= FRAME_IDLE;
			count_r <= '0;
			words_r <= '0;
			done_r  <= 1'b0;
		end else begin
			state_r <= state_n;
			done_r  <= close_fire_w;
			if (close_fire_w) begin
				// The closing word itself is part of the report
				words_r <= count_r + 1'b1;
				count_r <= '0;
			end else if (out_fire_w) begin
				count_r <= count_r + 1'b1;
			end
		end
	end

	assign frame_words_o = words_r;
	assign frame_done_o  = done_r;

endmodule

//--- stream_packer.sv
`timescale 1ns/1ps

module stream_packer
	(input  logic                     clk_i
	,input  logic                     reset_i

	,input  pk_stream_pkg::sym_t      sym_i
	,input  logic                     sym_valid_i
	,input  logic                     sym_last_i
	,output logic                     sym_ready_o

	,output pk_stream_pkg::word_t     word_o
	,output logic                     word_last_o
	,output logic                     word_valid_o
	,input  logic                     word_ready_i

	,output pk_ctrl_pkg::word_count_t frame_words_o
	,output logic                     frame_done_o
	);

	import pk_stream_pkg::*;

	// Controller side of the packer's input handshake
	logic  pk_valid_w;
	logic  pk_flush_w;
	logic  pk_ready_w;

	// Word that the packer presents in the cycle of its closing symbol
	word_t pk_word_w;
	logic  pk_word_last_w;
	logic  pk_word_valid_w;
	// Output stage room, the packer's back-pressure
	logic  el_ready_w;

	// The controller watches the delivered words to count them per frame
	frame_ctrl frame_ctrl_inst
		(.clk_i         (clk_i)
		,.reset_i       (reset_i)
		,.sym_valid_i   (sym_valid_i)
		,.sym_last_i    (sym_last_i)
		,.sym_ready_o   (sym_ready_o)
		,.pk_valid_o    (pk_valid_w)
		,.pk_flush_o    (pk_flush_w)
		,.pk_ready_i    (pk_ready_w)
		,.out_valid_i   (word_valid_o)
		,.out_ready_i   (word_ready_i)
		,.out_last_i    (word_last_o)
		,.frame_words_o (frame_words_o)
		,.frame_done_o  (frame_done_o)
		);

	packer packer_inst
		(.clk_i           (clk_i)
		,.reset_i         (reset_i)
		,.sym_i           (sym_i)
		,.valid_i         (pk_valid_w)
		,.flush_i         (pk_flush_w)
		,.ready_o         (pk_ready_w)
		,.word_o          (pk_word_w)
		,.word_last_o     (pk_word_last_w)
		,.word_valid_o    (pk_word_valid_w)
		,.elastic_ready_i (el_ready_w)
		);

	// Registered output, a word shows up one cycle after its closing symbol
	elastic elastic_inst
		(.clk_i   (clk_i)
		,.reset_i (reset_i)
		,.data_i  (pk_word_w)
		,.last_i  (pk_word_last_w)
		,.valid_i (pk_word_valid_w)
		,.ready_o (el_ready_w)
		,.data_o  (word_o)
		,.last_o  (word_last_o)
		,.valid_o (word_valid_o)
		,.ready_i (word_ready_i)
		);

endmodule

//--- tb_stream_packer_assert.sv
`timescale 1ns/1ps

module tb_stream_packer_assert
	(input logic                 clk_i
	,input logic                 reset_i
	,input logic                 sym_ready_o
	,input pk_stream_pkg::word_t word_o
	,input logic                 word_last_o
	,input logic                 word_valid_o
	,input logic                 word_ready_i
	,input logic                 frame_done_o
	);

	// A stalled word keeps its value and tag until the sink takes it
	hold_under_stall_a: assert property (@(posedge clk_i) disable iff (reset_i)
		(word_valid_o && !word_ready_i) |=>
		(word_valid_o && $stable(word_o) && $stable(word_last_o)))
		else $error("stalled output word changed or disappeared");

	// The frame report is a single-cycle pulse
	done_pulse_a: assert property (@(posedge clk_i) disable iff (reset_i)
		frame_done_o |=> !frame_done_o)
		else $error("frame_done_o high for two cycles in a row");

	// While the closing word waits, no symbol of the next frame may enter
	closing_blocks_input_a: assert property (@(posedge clk_i) disable iff (reset_i)
		(word_valid_o && word_last_o) |-> !sym_ready_o)
		else $error("sym_ready_o high while a closing word is pending");

	// Right after reset nothing is presented on the outputs
	clean_after_reset_a: assert property (@(posedge clk_i)
		$fell(reset_i) |-> (!word_valid_o && !frame_done_o))
		else $error("output valid right after reset");

endmodule

bind stream_packer tb_stream_packer_assert stream_packer_checks
	(.clk_i        (clk_i)
	,.reset_i      (reset_i)
	,.sym_ready_o  (sym_ready_o)
	,.word_o       (word_o)
	,.word_last_o  (word_last_o)
	,.word_valid_o (word_valid_o)
	,.word_ready_i (word_ready_i)
	,.frame_done_o (frame_done_o)
	);

//--- tb_stream_packer.sv
`timescale 1ns/1ps
`include "pk_consts.svh"

module tb_stream_packer;

	import pk_stream_pkg::*;
	import pk_ctrl_pkg::*;

	// Cycles that any single wait may last before it counts as a hang
	localparam int WAIT_LIMIT = 200;

	logic        clk_i = 1'b0;
	logic        reset_i;
	sym_t        sym_i;
	logic        sym_valid_i;
	logic        sym_last_i;
	logic        sym_ready_o;
	word_t       word_o;
	logic        word_last_o;
	logic        word_valid_o;
	logic        word_ready_i;
	word_count_t frame_words_o;
	logic        frame_done_o;

	int          error_count;
	int          check_total;
	logic [31:0] rng_state;
	// Words and tags taken from the output during the current test
	word_t       got_words[$];
	logic        got_lasts[$];
	// Counts published with each frame report during the current test
	word_count_t got_counts[$];

	stream_packer DUT (.*);

	always #10 clk_i = ~clk_i;

	// A report pulse and its count both come from registers and are settled at the negedge
	always @(negedge clk_i) begin
		if (frame_done_o)
			got_counts.push_back(frame_words_o);
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic report_timeout(input string what);
		error_count++;
		$display("Timeout while waiting for %s", what);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		check_total++;
		if (act !== exp) begin
			error_count++;
			$display("CHECK FAILED %s word expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		check_total++;
		if (act !== exp) begin
			error_count++;
			$display("CHECK FAILED %s flag expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input word_count_t exp,
		input word_count_t act);
		check_total++;
		if (act !== exp) begin
			error_count++;
			$display("CHECK FAILED %s count expected %0d actual %0d", name, exp, act);
		end
	endtask

	// Offers each symbol and holds it until a negedge sees ready, so the next edge takes it
	// Every frame_len-th symbol carries the last flag
	task automatic drive_frame(input sym_t syms[$], input int frame_len);
		int i;
		int guard;
		for (i = 0; i < syms.size(); i++) begin
			@(posedge clk_i);
			sym_i       <= syms[i];
			sym_valid_i <= 1'b1;
			sym_last_i  <= ((i + 1) % frame_len == 0);
			guard = 0;
			@(negedge clk_i);
			while (!sym_ready_o && guard < WAIT_LIMIT) begin
				@(negedge clk_i);
				guard++;
			end
			if (!sym_ready_o) begin
				report_timeout("sym_ready_o");
				break;
			end
		end
		@(posedge clk_i);
		sym_valid_i <= 1'b0;
		sym_last_i  <= 1'b0;
	endtask

	// Takes words until n_frames tagged ones have arrived and may stall the sink at random
	task automatic collect_words(input logic stall, input int n_frames);
		int          guard;
		int          lasts_seen;
		logic [31:0] r;
		lasts_seen = 0;
		guard      = 0;
		while (lasts_seen < n_frames && guard < WAIT_LIMIT) begin
			r = next_rand();
			@(posedge clk_i);
			word_ready_i <= stall ? r[0] : 1'b1;
			@(negedge clk_i);
			if (word_valid_o && word_ready_i) begin
				got_words.push_back(word_o);
				got_lasts.push_back(word_last_o);
				if (word_last_o)
					lasts_seen++;
				guard = 0;
			end else begin
				guard++;
			end
		end
		if (lasts_seen < n_frames)
			report_timeout("the closing word of the frame");
		@(posedge clk_i);
		word_ready_i <= 1'b1;
	endtask

	// Sends n_frames frames of n_syms symbols each with no gap between the frames
	task automatic run_frames(input string name, input int n_syms, input int n_frames,
		input logic stall);
		sym_t        syms[$];
		word_t       exp_words[$];
		logic [31:0] r;
		int          n_words;
		int          guard;
		int          k;
		int          j;
		int          w;
		got_words.delete();
		got_lasts.delete();
		got_counts.delete();
		for (k = 0; k < n_syms * n_frames; k++) begin
			r = next_rand();
			syms.push_back(sym_t'(r));
		end
		// Symbol j of a frame goes to word j/4 of that frame at bit 2*(j mod 4)
		// Bits that no symbol reaches stay zero
		n_words = (n_syms + `PK_SYMS_PER_WORD - 1) / `PK_SYMS_PER_WORD;
		for (k = 0; k < n_words * n_frames; k++)
			exp_words.push_back('0);
		for (k = 0; k < n_syms * n_frames; k++) begin
			j = k % n_syms;
			w = (k / n_syms) * n_words + j / `PK_SYMS_PER_WORD;
			exp_words[w] = exp_words[w]
				| (word_t'(syms[k]) << (`PK_SYM_WIDTH * (j % `PK_SYMS_PER_WORD)));
		end
		fork
			drive_frame(syms, n_syms);
			collect_words(stall, n_frames);
		join
		// The last report pulse follows the closing handshake by one cycle
		guard = 0;
		while (got_counts.size() < n_frames && guard < WAIT_LIMIT) begin
			@(posedge clk_i);
			guard++;
		end
		if (got_counts.size() < n_frames)
			report_timeout("frame_done_o");
		check_total++;
		if (got_words.size() != n_words * n_frames) begin
			error_count++;
			$display("CHECK FAILED %s words expected %0d actual %0d",
				name, n_words * n_frames, got_words.size());
		end
		for (k = 0; k < n_words * n_frames && k < got_words.size(); k++) begin
			check_word(name, exp_words[k], got_words[k]);
			// Only the final word of each frame carries the last tag
			check_flag(name, (k % n_words) == n_words - 1, got_lasts[k]);
		end
		for (k = 0; k < n_frames && k < got_counts.size(); k++)
			check_count(name, word_count_t'(n_words), got_counts[k]);
	endtask

	task automatic verify_reset_state();
		@(negedge clk_i);
		check_flag("reset word_valid_o", 1'b0, word_valid_o);
		check_flag("reset frame_done_o", 1'b0, frame_done_o);
		check_flag("reset sym_ready_o", 1'b1, sym_ready_o);
		check_count("reset frame_words_o", '0, frame_words_o);
	endtask

	task automatic pack_full_words();
		run_frames("full words", 8, 1, 1'b0);
	endtask

	task automatic close_partial_words();
		run_frames("partial 1", 1, 1, 1'b0);
		run_frames("partial 3", 3, 1, 1'b0);
		run_frames("partial 5", 5, 1, 1'b0);
	endtask

	// The second frame is offered while the closing word of the first is still pending
	task automatic split_back_to_back_frames();
		run_frames("single word frames", 4, 2, 1'b0);
	endtask

	task automatic stall_output_randomly();
		run_frames("back-pressure", 13, 1, 1'b1);
	endtask

	initial begin
		rng_state    = 32'h2dc7_2aea;
		error_count  = 0;
		check_total  = 0;
		reset_i      <= 1'b1;
		sym_i        <= '0;
		sym_valid_i  <= 1'b0;
		sym_last_i   <= 1'b0;
		word_ready_i <= 1'b1;
		repeat (8) @(posedge clk_i);
		reset_i <= 1'b0;
		verify_reset_state();
		pack_full_words();
		close_partial_words();
		split_back_to_back_frames();
		stall_output_randomly();
		$display("Checks run: %0d, errors: %0d", check_total, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+.
pk_stream_pkg.sv
pk_ctrl_pkg.sv
packer.sv
elastic.sv
frame_ctrl.sv
stream_packer.sv
tb_stream_packer_assert.sv
tb_stream_packer.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_stream_packer
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
